// File: tb.f
source/soc_pkg.sv
source/soc_req_if.sv
source/addr_decode.sv
source/l2_mem.sv
source/ctrl_regs.sv
source/uart_apb_bridge.sv
source/resp_merge.sv
source/soc_top.sv
verification/tb_soc.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it into sim.log and fails on a reported failure
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc -o sim_tb_soc
./obj_dir/sim_tb_soc | tee sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi

// File: verification/tb_soc.sv
// Random-traffic testbench for soc_top, checked against a fabric model and an APB responder
module tb_soc;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_pkg::*;

  localparam int unsigned L2NumWords = 1024;
  localparam int unsigned L2Window   = 16;
  localparam int unsigned NumRandom  = 500;
  localparam int unsigned NumTxn     = NumRandom + 2 * L2Window;
  localparam int unsigned CycleLimit = NumTxn * 8 + 100;
  localparam logic [DataWidth-1:0] DramEndExp = DataWidth'(DramBase) + DataWidth'(L2NumWords * 8);

  typedef struct {
    logic                 is_uart;
    logic [DataWidth-1:0] rdata;
    logic                 err;
    int unsigned          due;
  } rsp_exp_t;

  typedef struct {
    logic                    we;
    logic [AddrWidth-1:0]    paddr;
    logic [ApbDataWidth-1:0] pwdata;
  } apb_exp_t;

  typedef struct {
    logic [DataWidth-1:0] value;
    int unsigned          due;
  } exit_exp_t;

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic                    req;
  logic                    we;
  logic [AddrWidth-1:0]    addr;
  logic [DataWidth-1:0]    wdata;
  logic [DataWidth/8-1:0]  be;
  logic                    ready;
  logic                    rsp_valid;
  logic [DataWidth-1:0]    rsp_rdata;
  logic                    rsp_err;
  logic [DataWidth-1:0]    exit_val;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [AddrWidth-1:0]    paddr;
  logic [ApbDataWidth-1:0] pwdata;
  logic [ApbDataWidth-1:0] prdata;
  logic                    pready;
  logic                    pslverr;

  // Model state
  logic [DataWidth-1:0] l2_model [L2NumWords];
  logic [DataWidth-1:0] exit_model;
  rsp_exp_t             rsp_q[$];
  rsp_exp_t             uart_q[$];
  apb_exp_t             apb_q[$];
  exit_exp_t            exit_hist_q[$];
  int unsigned          cycles     = 0;
  int unsigned          mismatches = 0;
  int unsigned          failures   = 0;

  soc_top #(
    .L2NumWords(L2NumWords)
  ) u_dut (
    .clk_i         (clk      ),
    .arst_n_i      (arst_n   ),
    .req_i         (req      ),
    .we_i          (we       ),
    .addr_i        (addr     ),
    .wdata_i       (wdata    ),
    .be_i          (be       ),
    .ready_o       (ready    ),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata),
    .rsp_err_o     (rsp_err  ),
    .exit_o        (exit_val ),
    .uart_psel_o   (psel     ),
    .uart_penable_o(penable  ),
    .uart_pwrite_o (pwrite   ),
    .uart_paddr_o  (paddr    ),
    .uart_pwdata_o (pwdata   ),
    .uart_prdata_i (prdata   ),
    .uart_pready_i (pready   ),
    .uart_pslverr_i(pslverr  )
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", CycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_exit(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: exit_o got 0x%h, expected 0x%h", $time, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [AddrWidth-1:0] got,
                            input logic [AddrWidth-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_apb_data(input string name, input logic [ApbDataWidth-1:0] got,
                                input logic [ApbDataWidth-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0]   old_word,
                                                       input logic [DataWidth-1:0]   new_word,
                                                       input logic [DataWidth/8-1:0] strobe);
    logic [DataWidth-1:0] result;
    for (int b = 0; b < DataWidth / 8; b++) begin
      result[8*b +: 8] = strobe[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic pick_address(output soc_target_e kind, output logic [AddrWidth-1:0] a);
    int unsigned sel;
    int unsigned idx;
    logic [3:0]  tag;
    sel = $urandom_range(9, 0);
    if (sel < 4) begin
      // Both ends of L2, so the bound is exercised
      kind = TgtL2;
      idx  = $urandom_range(L2Window - 1, 0);
      if ($urandom_range(1, 0) == 1) idx = L2NumWords - 1 - idx;
      a = DramBase + AddrWidth'(idx * 8);
    end else if (sel < 6) begin
      kind = TgtCtrl;
      case ($urandom_range(3, 0))
        0:       a = CtrlBase + 32'h0;
        1:       a = CtrlBase + 32'h8;
        2:       a = CtrlBase + 32'h10;
        default: a = CtrlBase + ($urandom_range(32'hfff, 0) & 32'hff8);
      endcase
    end else if (sel < 8) begin
      kind = TgtUart;
      a    = UartBase + ($urandom_range(32'hfff, 0) & 32'hffc);
    end else begin
      kind = TgtNone;
      case ($urandom_range(2, 0))
        0: a = DramBase + AddrWidth'(L2NumWords * 8) + ($urandom_range(32'hffff, 0) & 32'hfff8);
        1: a = (($urandom_range(1, 0) == 1) ? UartBase : CtrlBase) + PeriphLength +
               $urandom_range(32'hfff, 0);
        default: begin
          tag = 4'($urandom_range(15, 0));
          if (tag == DramBase[31:28] || tag == UartBase[31:28] || tag == CtrlBase[31:28]) begin
            tag = 4'h1;
          end
          a = {tag, 28'($urandom)};
        end
      endcase
    end
  endtask

  // Called at the falling edge before the accepting edge
  task automatic model_request(input soc_target_e kind, input logic w,
                               input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] d,
                               input logic [DataWidth/8-1:0] strobe);
    rsp_exp_t             rsp;
    apb_exp_t             apb;
    exit_exp_t            ex;
    int unsigned          idx;
    logic [AddrWidth-1:0] off;
    rsp.is_uart = 1'b0;
    rsp.rdata   = '0;
    rsp.err     = 1'b0;
    rsp.due     = cycles + 3;
    case (kind)
      TgtL2: begin
        idx = (a - DramBase) >> 3;
        if (w) l2_model[idx] = merge_bytes(l2_model[idx], d, strobe);
        else rsp.rdata = l2_model[idx];
      end
      TgtCtrl: begin
        off = a - CtrlBase;
        if (w && off == 32'h0) begin
          exit_model = merge_bytes(exit_model, d, strobe);
          ex.value   = exit_model;
          ex.due     = cycles + 2;
          exit_hist_q.push_back(ex);
        end else if (!w) begin
          case (off)
            32'h0:   rsp.rdata = exit_model;
            32'h8:   rsp.rdata = DataWidth'(DramBase);
            32'h10:  rsp.rdata = DramEndExp;
            default: rsp.rdata = '0;
          endcase
        end
      end
      TgtUart: begin
        rsp.is_uart = 1'b1;
        apb.we      = w;
        apb.paddr   = a - UartBase;
        apb.pwdata  = d[ApbDataWidth-1:0];
        apb_q.push_back(apb);
      end
      default: rsp.err = 1'b1;
    endcase
    rsp_q.push_back(rsp);
  endtask

  // Holds the request until ready_o lets it in
  task automatic send(input soc_target_e kind, input logic w, input logic [AddrWidth-1:0] a,
                      input logic [DataWidth-1:0] d, input logic [DataWidth/8-1:0] strobe);
    @(negedge clk);
    req   = 1'b1;
    we    = w;
    addr  = a;
    wdata = d;
    be    = strobe;
    while (!ready) @(negedge clk);
    model_request(kind, w, a, d, strobe);
    if (kind == TgtUart) begin
      @(negedge clk);
      check_bit("ready_o", ready, 1'b0);
    end
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      req = 1'b0;
    end
  endtask

  initial begin : stimulus
    soc_target_e          kind;
    logic [AddrWidth-1:0] a;
    void'($urandom(32'hc9c60724));
    arst_n     = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    be         = '0;
    prdata     = '0;
    pready     = 1'b0;
    pslverr    = 1'b0;
    exit_model = '0;
    repeat (5) @(negedge clk);
    check_bit("ready_o", ready, 1'b0);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    check_bit("uart_psel_o", psel, 1'b0);
    check_bit("uart_penable_o", penable, 1'b0);
    check_exit(exit_val, '0);
    arst_n = 1'b1;
    // Full-word writes give every L2 word in use a known value
    for (int i = 0; i < L2Window; i++) begin
      send(TgtL2, 1'b1, DramBase + AddrWidth'(i * 8), {$urandom, $urandom}, '1);
      send(TgtL2, 1'b1, DramBase + AddrWidth'((L2NumWords - 1 - i) * 8), {$urandom, $urandom},
           '1);
    end
    for (int n = 0; n < NumRandom; n++) begin
      pick_address(kind, a);
      send(kind, 1'($urandom), a, {$urandom, $urandom}, 8'($urandom));
      if ($urandom_range(3, 0) == 0) idle($urandom_range(2, 1));
    end
    idle(1);
    while (rsp_q.size() != 0 || exit_hist_q.size() != 0) @(negedge clk);
    if (apb_q.size() != 0 || uart_q.size() != 0) begin
      failures++;
      $display("APB transfers left over after the last response");
    end
    $display("Closing counts: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // APB slave with 0 to 3 wait states
  always @(negedge clk) begin : apb_responder
    apb_exp_t    exp;
    rsp_exp_t    ret;
    int unsigned waits;
    if (arst_n && psel && !penable) begin
      check_bit("ready_o", ready, 1'b0);
      if (apb_q.size() == 0) begin
        failures++;
        $display("APB setup at %0t with no UART request outstanding", $time);
      end else begin
        exp = apb_q.pop_front();
        check_bit("uart_pwrite_o", pwrite, exp.we);
        check_addr("uart_paddr_o", paddr, exp.paddr);
        check_apb_data("uart_pwdata_o", pwdata, exp.pwdata);
      end
      waits = $urandom_range(3, 0);
      repeat (waits + 1) begin
        @(negedge clk);
        check_bit("uart_psel_o", psel, 1'b1);
        check_bit("uart_penable_o", penable, 1'b1);
        check_bit("ready_o", ready, 1'b0);
      end
      prdata      = $urandom;
      pslverr     = ($urandom_range(7, 0) == 0);
      pready      = 1'b1;
      ret.is_uart = 1'b1;
      ret.rdata   = {{(DataWidth - ApbDataWidth){1'b0}}, prdata};
      ret.err     = pslverr;
      ret.due     = cycles + 2;
      uart_q.push_back(ret);
      @(negedge clk);
      pready  = 1'b0;
      pslverr = 1'b0;
    end
  end

  always @(negedge clk) begin : response_check
    rsp_exp_t exp;
    rsp_exp_t uart;
    logic     known;
    if (arst_n && rsp_valid) begin
      if (rsp_q.size() == 0) begin
        failures++;
        $display("Response at %0t with no request outstanding", $time);
      end else begin
        exp   = rsp_q.pop_front();
        known = 1'b1;
        if (exp.is_uart) begin
          if (uart_q.size() == 0) begin
            known = 1'b0;
            failures++;
            $display("UART response at %0t before its APB transfer finished", $time);
          end else begin
            uart      = uart_q.pop_front();
            exp.rdata = uart.rdata;
            exp.err   = uart.err;
            exp.due   = uart.due;
          end
        end
        if (known) begin
          if (cycles != exp.due) begin
            failures++;
            $display("Response at %0t came in cycle %0d instead of cycle %0d",
                     $time, cycles, exp.due);
          end
          check_data("rsp_rdata_o", rsp_rdata, exp.rdata);
          check_bit("rsp_err_o", rsp_err, exp.err);
        end
      end
    end
  end

  // Exit register lands two edges after acceptance
  always @(negedge clk) begin : exit_check
    if (exit_hist_q.size() != 0 && exit_hist_q[0].due == cycles) begin
      check_exit(exit_val, exit_hist_q[0].value);
      exit_hist_q.delete(0);
    end
  end

endmodule : tb_soc

// File: source/soc_top.sv
// Top level of the fabric: request port in, one response per request out, UART over APB
module soc_top #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  // Request port
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [soc_pkg::AddrWidth-1:0]    addr_i,
  input  logic [soc_pkg::DataWidth-1:0]    wdata_i,
  input  logic [soc_pkg::DataWidth/8-1:0]  be_i,
  output logic                             ready_o,
  // Response port
  output logic                             rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0]    rsp_rdata_o,
  output logic                             rsp_err_o,
  output logic [soc_pkg::DataWidth-1:0]    exit_o,
  // UART APB
  output logic                             uart_psel_o,
  output logic                             uart_penable_o,
  output logic                             uart_pwrite_o,
  output logic [soc_pkg::AddrWidth-1:0]    uart_paddr_o,
  output logic [soc_pkg::ApbDataWidth-1:0] uart_pwdata_o,
  input  logic [soc_pkg::ApbDataWidth-1:0] uart_prdata_i,
  input  logic                             uart_pready_i,
  input  logic                             uart_pslverr_i
);
  import soc_pkg::*;

  logic                 uart_busy;
  logic                 l2_valid,  ctrl_valid,  uart_valid;
  logic [DataWidth-1:0] l2_rdata,  ctrl_rdata,  uart_rdata;
  logic                 l2_err,    ctrl_err,    uart_err;

  soc_req_if req_bus ();

  addr_decode #(
    .L2NumWords(L2NumWords)
  ) i_addr_decode (
    .clk_i      (clk_i    ),
    .arst_n_i   (arst_n_i ),
    .req_i      (req_i    ),
    .we_i       (we_i     ),
    .addr_i     (addr_i   ),
    .wdata_i    (wdata_i  ),
    .be_i       (be_i     ),
    .uart_busy_i(uart_busy),
    .ready_o    (ready_o  ),
    .req        (req_bus  )
  );

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i      (clk_i   ),
    .arst_n_i   (arst_n_i),
    .req        (req_bus ),
    .rsp_valid_o(l2_valid),
    .rsp_rdata_o(l2_rdata),
    .rsp_err_o  (l2_err  )
  );

  // DRAM end follows the L2 size
  ctrl_regs #(
    .DramEnd(DataWidth'(DramBase) + DataWidth'(L2NumWords) * 8)
  ) i_ctrl_regs (
    .clk_i      (clk_i     ),
    .arst_n_i   (arst_n_i  ),
    .req        (req_bus   ),
    .rsp_valid_o(ctrl_valid),
    .rsp_rdata_o(ctrl_rdata),
    .rsp_err_o  (ctrl_err  ),
    .exit_o     (exit_o    )
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .req           (req_bus       ),
    .busy_o        (uart_busy     ),
    .rsp_valid_o   (uart_valid    ),
    .rsp_rdata_o   (uart_rdata    ),
    .rsp_err_o     (uart_err      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  resp_merge i_resp_merge (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req         (req_bus    ),
    .l2_valid_i  (l2_valid   ),
    .l2_rdata_i  (l2_rdata   ),
    .l2_err_i    (l2_err     ),
    .ctrl_valid_i(ctrl_valid ),
    .ctrl_rdata_i(ctrl_rdata ),
    .ctrl_err_i  (ctrl_err   ),
    .uart_valid_i(uart_valid ),
    .uart_rdata_i(uart_rdata ),
    .uart_err_i  (uart_err   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  )
  );

endmodule : soc_top

// File: source/resp_merge.sv
// Last stage: folds the target responses and unmapped-address errors into one response
module resp_merge (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  soc_req_if.dst                        req,
  input  logic                          l2_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] l2_rdata_i,
  input  logic                          l2_err_i,
  input  logic                          ctrl_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] ctrl_rdata_i,
  input  logic                          ctrl_err_i,
  input  logic                          uart_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] uart_rdata_i,
  input  logic                          uart_err_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o
);
  import soc_pkg::*;

  logic none_q;

  // Unmapped requests wait one cycle to line up with the targets
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      none_q      <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      none_q      <= req.valid && req.target == TgtNone;
      rsp_valid_o <= l2_valid_i | ctrl_valid_i | uart_valid_i | none_q;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_rdata_o <= ({DataWidth{l2_valid_i}} & l2_rdata_i) |
                   ({DataWidth{ctrl_valid_i}} & ctrl_rdata_i) |
                   ({DataWidth{uart_valid_i}} & uart_rdata_i);
    rsp_err_o   <= (l2_valid_i & l2_err_i) | (ctrl_valid_i & ctrl_err_i) |
                   (uart_valid_i & uart_err_i) | none_q;
  end

  // In-order pipeline, so targets never answer together
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({l2_valid_i, ctrl_valid_i, uart_valid_i, none_q}));

endmodule : resp_merge

// File: source/uart_apb_bridge.sv
// UART target: turns one decoded request into an APB transfer and waits out pready
module uart_apb_bridge (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  soc_req_if.dst                           req,
  output logic                             busy_o,
  output logic                             rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0]    rsp_rdata_o,
  output logic                             rsp_err_o,
  output logic                             uart_psel_o,
  output logic                             uart_penable_o,
  output logic                             uart_pwrite_o,
  output logic [soc_pkg::AddrWidth-1:0]    uart_paddr_o,
  output logic [soc_pkg::ApbDataWidth-1:0] uart_pwdata_o,
  input  logic [soc_pkg::ApbDataWidth-1:0] uart_prdata_i,
  input  logic                             uart_pready_i,
  input  logic                             uart_pslverr_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    Idle   = 2'd0,
    Setup  = 2'd1,
    Access = 2'd2
  } state_e;

  state_e state_q;
  logic   hit;
  logic   done;

  assign hit  = req.valid && req.target == TgtUart;
  assign done = state_q == Access && uart_pready_i;

  // Busy from the cycle the request arrives until pready completes it
  assign busy_o         = hit || state_q != Idle;
  assign uart_psel_o    = state_q != Idle;
  assign uart_penable_o = state_q == Access;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= Idle;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= done;
      case (state_q)
        Idle:    if (hit) state_q <= Setup;
        Setup:   state_q <= Access;
        Access:  if (uart_pready_i) state_q <= Idle;
        default: state_q <= Idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfer and response payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == Idle && hit) begin
      uart_pwrite_o <= req.we;
      uart_paddr_o  <= AddrWidth'(req.offset);
      uart_pwdata_o <= req.wdata[ApbDataWidth-1:0];
    end
    if (done) begin
      rsp_rdata_o <= DataWidth'(uart_prdata_i);
      rsp_err_o   <= uart_pslverr_i;
    end
  end

  // Decode holds new UART requests off until the transfer ends
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hit |-> state_q == Idle);

endmodule : uart_apb_bridge

// File: source/ctrl_regs.sv
// Control register target: writable exit register and read-only DRAM bounds
module ctrl_regs #(
  parameter logic [soc_pkg::DataWidth-1:0] DramEnd = 64'h8000_2000
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  soc_req_if.dst                        req,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o,
  output logic [soc_pkg::DataWidth-1:0] exit_o
);
  import soc_pkg::*;

  logic                 hit;
  logic [DataWidth-1:0] exit_q;
  logic [DataWidth-1:0] rdata_d;

  assign hit       = req.valid && req.target == TgtCtrl;
  assign exit_o    = exit_q;
  assign rsp_err_o = 1'b0;

  // Unknown offsets read as zero
  always_comb begin
    case (req.offset)
      CtrlExitOffset:     rdata_d = exit_q;
      CtrlDramBaseOffset: rdata_d = DataWidth'(DramBase);
      CtrlDramEndOffset:  rdata_d = DramEnd;
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_q      <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= hit;
      // Only exit takes writes
      if (hit && req.we && req.offset == CtrlExitOffset) begin
        exit_q <= apply_be(exit_q, req.wdata, req.be);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit) begin
      rsp_rdata_o <= req.we ? '0 : rdata_d;
    end
  end

endmodule : ctrl_regs

// File: source/l2_mem.sv
// L2 memory target: single-port SRAM with byte enables and a one-cycle registered read
module l2_mem #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  soc_req_if.dst                        req,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o
);
  import soc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(L2NumWords);

  logic [DataWidth-1:0] mem [L2NumWords];
  logic [IdxWidth-1:0]  idx;
  logic                 hit;

  // Word index, 8 bytes per word
  assign idx = req.offset[IdxWidth+2:3];
  assign hit = req.valid && req.target == TgtL2;

  assign rsp_err_o = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit) begin
      if (req.we) begin
        mem[idx]    <= apply_be(mem[idx], req.wdata, req.be);
        rsp_rdata_o <= '0;
      end else begin
        rsp_rdata_o <= mem[idx];
      end
    end
  end

  // Decode bounds keep every L2 access inside the array
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hit |-> (req.offset >> 3) < L2NumWords);

endmodule : l2_mem

// File: source/addr_decode.sv
// First pipeline stage: accepts a top-level request, picks its region and registers it
module addr_decode #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  soc_pkg::soc_addr_u             addr_i,
  input  logic [soc_pkg::DataWidth-1:0]   wdata_i,
  input  logic [soc_pkg::DataWidth/8-1:0] be_i,
  input  logic                           uart_busy_i,
  output logic                           ready_o,
  soc_req_if.src                         req
);
  import soc_pkg::*;

  localparam logic [AddrWidth-1:0] L2End = DramBase + AddrWidth'(L2NumWords * 8);

  logic        ready_q;
  logic        accept;
  soc_target_e target_d;

  // Held low until the first edge out of reset, and while the UART is busy
  assign ready_o = ready_q & ~uart_busy_i;
  assign accept  = req_i & ready_o;

  // Region from the tag, bounds from the raw address or the offset
  always_comb begin
    target_d = TgtNone;
    if (addr_i.f.tag == DramBase[AddrWidth-1 -: TagWidth] && addr_i.raw < L2End) begin
      target_d = TgtL2;
    end else if (addr_i.f.tag == UartBase[AddrWidth-1 -: TagWidth] &&
                 addr_i.f.offset < PeriphLength) begin
      target_d = TgtUart;
    end else if (addr_i.f.tag == CtrlBase[AddrWidth-1 -: TagWidth] &&
                 addr_i.f.offset < PeriphLength) begin
      target_d = TgtCtrl;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q   <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      ready_q   <= 1'b1;
      req.valid <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req.target <= target_d;
      req.we     <= we_i;
      req.offset <= addr_i.f.offset;
      req.wdata  <= wdata_i;
      req.be     <= be_i;
    end
  end

  // A UART request in the pipe holds off the next one
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req.valid && req.target == TgtUart |-> !ready_o);

endmodule : addr_decode

// File: source/soc_req_if.sv
// Decoded request from the decode stage, fanned out to every target and the response merge
interface soc_req_if;
  import soc_pkg::*;

  logic                     valid;
  soc_target_e              target;
  logic                     we;
  logic [OffsetWidth-1:0]   offset;
  logic [DataWidth-1:0]     wdata;
  logic [DataWidth/8-1:0]   be;

  modport src (
    output valid,
    output target,
    output we,
    output offset,
    output wdata,
    output be
  );

  modport dst (
    input valid,
    input target,
    input we,
    input offset,
    input wdata,
    input be
  );

endinterface : soc_req_if

// File: source/soc_pkg.sv
// Shared address map, bus widths and request types, imported by every RTL block of the fabric
package soc_pkg;

  localparam int unsigned DataWidth    = 64;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned TagWidth     = 4;
  localparam int unsigned OffsetWidth  = AddrWidth - TagWidth;

  ////////////////////////////////////////////////////////////////////////////
  // Memory map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [AddrWidth-1:0] DramBase     = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] UartBase     = 32'hC000_0000;
  localparam logic [AddrWidth-1:0] CtrlBase     = 32'hD000_0000;
  localparam logic [AddrWidth-1:0] PeriphLength = 32'h0000_1000;

  // Control register offsets
  localparam logic [OffsetWidth-1:0] CtrlExitOffset     = 28'h0;
  localparam logic [OffsetWidth-1:0] CtrlDramBaseOffset = 28'h8;
  localparam logic [OffsetWidth-1:0] CtrlDramEndOffset  = 28'h10;

  // Raw address, or region tag plus offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [TagWidth-1:0]    tag;
      logic [OffsetWidth-1:0] offset;
    } f;
  } soc_addr_u;

  typedef enum logic [1:0] {
    TgtL2   = 2'd0,
    TgtUart = 2'd1,
    TgtCtrl = 2'd2,
    TgtNone = 2'd3
  } soc_target_e;

  // Byte-enable merge of new data over an old word
  function automatic logic [DataWidth-1:0] apply_be(
    input logic [DataWidth-1:0]   old_data,
    input logic [DataWidth-1:0]   new_data,
    input logic [DataWidth/8-1:0] be
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int i = 0; i < DataWidth / 8; i++) begin
      if (be[i]) merged[8*i +: 8] = new_data[8*i +: 8];
    end
    return merged;
  endfunction

endpackage : soc_pkg
